//--- build.f
source/rv_pkg.sv
source/fetch_unit.sv
source/decoder.sv
source/reg_file.sv
source/alu.sv
source/hazard_unit.sv
source/cpu_core.sv
tests/tb_clock.sv
tests/cpu_sva.sv
tests/tb_cpu.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the pipeline testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_cpu -f build.f -o sim_cpu \
  > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/sim_cpu > sim.log 2>&1
cat sim.log

grep -q "=== FAIL ===" sim.log && { echo "Simulation failed"; exit 1; }
grep -q "=== PASS ===" sim.log || { echo "Simulation ended without passing"; exit 1; }
echo "Simulation passed"

//--- source/alu.sv
`timescale 1ns/1ps
module alu (
  input  rv_pkg::alu_op_e op_i,
  input  rv_pkg::word_t   a_i,
  input  rv_pkg::word_t   b_i,
  output rv_pkg::word_t   result_o,
  output logic            equal_o
);

  logic less_signed;

  // Equality drives branch resolution
  assign equal_o     = (a_i == b_i);
  assign less_signed = ($signed(a_i) < $signed(b_i));

  always_comb begin
    case (op_i)
      rv_pkg::ALU_ADD:    result_o = a_i + b_i;
      rv_pkg::ALU_SUB:    result_o = a_i - b_i;
      rv_pkg::ALU_AND:    result_o = a_i & b_i;
      rv_pkg::ALU_OR:     result_o = a_i | b_i;
      rv_pkg::ALU_XOR:    result_o = a_i ^ b_i;
      // Signed set-less-than, result in bit 0
      rv_pkg::ALU_SLT:    result_o = {31'b0, less_signed};
      // Upper immediate passes straight through
      rv_pkg::ALU_PASS_B: result_o = b_i;
      rv_pkg::ALU_EQ:     result_o = {31'b0, equal_o};
      default:            result_o = a_i + b_i;
    endcase
  end

endmodule

//--- source/cpu_core.sv
`timescale 1ns/1ps
module cpu_core #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  output rv_pkg::word_t imem_addr_o,
  input  rv_pkg::word_t imem_rdata_i,
  output rv_pkg::word_t dmem_addr_o,
  output rv_pkg::word_t dmem_wdata_o,
  input  rv_pkg::word_t dmem_rdata_i,
  output logic          dmem_we_o,
  output logic          dmem_re_o
);

  // Hazard control
  logic              stall;
  logic              flush;
  logic              redirect;
  rv_pkg::fwd_sel_e  fwd_a;
  rv_pkg::fwd_sel_e  fwd_b;
  // Fetch and decode stage
  rv_pkg::word_t     pc_f;
  rv_pkg::word_t     pc_d;
  rv_pkg::word_t     instr_d;
  rv_pkg::reg_addr_t rs1_d, rs2_d, rd_d;
  rv_pkg::word_t     imm_d, rd1_d, rd2_d;
  rv_pkg::alu_op_e   alu_sel_d;
  logic              use_imm_d, reg_write_d, mem_read_d, mem_write_d;
  logic              branch_d, branch_ne_d;
  // Execute stage
  rv_pkg::word_t     pc_e, imm_e, rd1_e, rd2_e;
  rv_pkg::reg_addr_t rs1_e, rs2_e, rd_e;
  rv_pkg::alu_op_e   alu_sel_e;
  logic              use_imm_e, reg_write_e, mem_read_e, mem_write_e;
  logic              branch_e, branch_ne_e;
  rv_pkg::word_t     op_a, op_b, alu_b, alu_res, target;
  logic              alu_eq;
  // Memory and writeback stage
  rv_pkg::word_t     alu_m, wdata_m, alu_w, load_w, wb_data;
  rv_pkg::reg_addr_t rd_m, rd_w;
  logic              reg_write_m, mem_read_m, mem_write_m;
  logic              reg_write_w, mem_read_w;

  // ========================================
  // Fetch
  // ========================================
  fetch_unit #(
    .RESET_PC(RESET_PC)
  ) u_fetch (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .stall_i   (stall),
    .redirect_i(redirect),
    .target_i  (target),
    .pc_o      (pc_f)
  );

  assign imem_addr_o = pc_f;

  // Fetch/decode register, held on stall and squashed on flush
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush) begin
      instr_d <= rv_pkg::NOP_INSTR;
    end else if (!stall) begin
      instr_d <= imem_rdata_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!stall) begin
      pc_d <= pc_f;
    end
  end

  // ========================================
  // Decode
  // ========================================
  decoder u_decoder (
    .instr_i    (instr_d),
    .rs1_o      (rs1_d),
    .rs2_o      (rs2_d),
    .rd_o       (rd_d),
    .imm_o      (imm_d),
    .alu_op_o   (alu_sel_d),
    .use_imm_o  (use_imm_d),
    .reg_write_o(reg_write_d),
    .mem_read_o (mem_read_d),
    .mem_write_o(mem_write_d),
    .branch_o   (branch_d),
    .branch_ne_o(branch_ne_d)
  );

  // Writeback lands here, bypassed to decode in the same cycle
  reg_file u_reg_file (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .rs1_i   (rs1_d),
    .rs2_i   (rs2_d),
    .rd_i    (rd_w),
    .we_i    (reg_write_w),
    .wdata_i (wb_data),
    .rdata1_o(rd1_d),
    .rdata2_o(rd2_d)
  );

  // Decode/execute control, bubble on stall or flush
  always_ff @(posedge clk_i) begin
    if (!rst_ni || flush || stall) begin
      reg_write_e <= 1'b0;
      mem_read_e  <= 1'b0;
      mem_write_e <= 1'b0;
      branch_e    <= 1'b0;
      branch_ne_e <= 1'b0;
    end else begin
      reg_write_e <= reg_write_d;
      mem_read_e  <= mem_read_d;
      mem_write_e <= mem_write_d;
      branch_e    <= branch_d;
      branch_ne_e <= branch_ne_d;
    end
  end

  always_ff @(posedge clk_i) begin
    pc_e      <= pc_d;
    imm_e     <= imm_d;
    rd1_e     <= rd1_d;
    rd2_e     <= rd2_d;
    rs1_e     <= rs1_d;
    rs2_e     <= rs2_d;
    rd_e      <= rd_d;
    alu_sel_e <= alu_sel_d;
    use_imm_e <= use_imm_d;
  end

  // ========================================
  // Execute
  // ========================================
  // Forwarded operands, memory stage carries the ALU result only
  always_comb begin
    case (fwd_a)
      rv_pkg::FWD_MEM: op_a = alu_m;
      rv_pkg::FWD_WB:  op_a = wb_data;
      default:         op_a = rd1_e;
    endcase
    case (fwd_b)
      rv_pkg::FWD_MEM: op_b = alu_m;
      rv_pkg::FWD_WB:  op_b = wb_data;
      default:         op_b = rd2_e;
    endcase
  end

  assign alu_b = use_imm_e ? imm_e : op_b;

  alu u_alu (
    .op_i    (alu_sel_e),
    .a_i     (op_a),
    .b_i     (alu_b),
    .result_o(alu_res),
    .equal_o (alu_eq)
  );

  // Not-taken prediction, taken branch redirects fetch
  assign target   = pc_e + imm_e;
  assign redirect = branch_e && (alu_eq ^ branch_ne_e);

  hazard_unit u_hazard (
    .rs1_d_i      (rs1_d),
    .rs2_d_i      (rs2_d),
    .rs1_e_i      (rs1_e),
    .rs2_e_i      (rs2_e),
    .rd_e_i       (rd_e),
    .rd_m_i       (rd_m),
    .rd_w_i       (rd_w),
    .mem_read_e_i (mem_read_e),
    .reg_write_m_i(reg_write_m),
    .reg_write_w_i(reg_write_w),
    .redirect_i   (redirect),
    .stall_o      (stall),
    .flush_o      (flush),
    .fwd_a_o      (fwd_a),
    .fwd_b_o      (fwd_b)
  );

  // ========================================
  // Memory and writeback
  // ========================================
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      reg_write_m <= 1'b0;
      mem_read_m  <= 1'b0;
      mem_write_m <= 1'b0;
      reg_write_w <= 1'b0;
      mem_read_w  <= 1'b0;
    end else begin
      reg_write_m <= reg_write_e;
      mem_read_m  <= mem_read_e;
      mem_write_m <= mem_write_e;
      reg_write_w <= reg_write_m;
      mem_read_w  <= mem_read_m;
    end
  end

  always_ff @(posedge clk_i) begin
    alu_m   <= alu_res;
    wdata_m <= op_b;
    rd_m    <= rd_e;
    alu_w   <= alu_m;
    load_w  <= dmem_rdata_i;
    rd_w    <= rd_m;
  end

  // Data memory answers in the same cycle
  assign dmem_addr_o  = alu_m;
  assign dmem_wdata_o = wdata_m;
  assign dmem_we_o    = mem_write_m;
  assign dmem_re_o    = mem_read_m;

  // Load data or ALU result back to the register file
  assign wb_data = mem_read_w ? load_w : alu_w;

endmodule

//--- source/decoder.sv
`timescale 1ns/1ps
module decoder (
  input  rv_pkg::word_t     instr_i,
  output rv_pkg::reg_addr_t rs1_o,
  output rv_pkg::reg_addr_t rs2_o,
  output rv_pkg::reg_addr_t rd_o,
  output rv_pkg::word_t     imm_o,
  output rv_pkg::alu_op_e   alu_op_o,
  output logic              use_imm_o,
  output logic              reg_write_o,
  output logic              mem_read_o,
  output logic              mem_write_o,
  output logic              branch_o,
  output logic              branch_ne_o
);

  logic [6:0]    opcode;
  logic [2:0]    funct3;
  logic [6:0]    funct7;
  rv_pkg::word_t imm_i_type;
  rv_pkg::word_t imm_s_type;
  rv_pkg::word_t imm_b_type;
  rv_pkg::word_t imm_u_type;

  // Fixed instruction fields
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign rd_o   = instr_i[11:7];
  assign rs1_o  = instr_i[19:15];
  assign rs2_o  = instr_i[24:20];

  // Sign-extended immediates of each format
  assign imm_i_type = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s_type = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_b_type = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                       instr_i[11:8], 1'b0};
  assign imm_u_type = {instr_i[31:12], 12'b0};

  // Anything not matched below leaves every enable low
  always_comb begin
    imm_o       = imm_i_type;
    alu_op_o    = rv_pkg::ALU_ADD;
    use_imm_o   = 1'b0;
    reg_write_o = 1'b0;
    mem_read_o  = 1'b0;
    mem_write_o = 1'b0;
    branch_o    = 1'b0;
    branch_ne_o = 1'b0;
    case (opcode)
      rv_pkg::OPC_OP: begin
        reg_write_o = 1'b1;
        case ({funct7, funct3})
          {7'h00, 3'b000}: alu_op_o = rv_pkg::ALU_ADD;
          {7'h20, 3'b000}: alu_op_o = rv_pkg::ALU_SUB;
          {7'h00, 3'b111}: alu_op_o = rv_pkg::ALU_AND;
          {7'h00, 3'b110}: alu_op_o = rv_pkg::ALU_OR;
          {7'h00, 3'b100}: alu_op_o = rv_pkg::ALU_XOR;
          {7'h00, 3'b010}: alu_op_o = rv_pkg::ALU_SLT;
          default:         reg_write_o = 1'b0;
        endcase
      end
      rv_pkg::OPC_OP_IMM: begin
        // Only ADDI is kept
        use_imm_o   = (funct3 == 3'b000);
        reg_write_o = (funct3 == 3'b000);
      end
      rv_pkg::OPC_LUI: begin
        imm_o       = imm_u_type;
        alu_op_o    = rv_pkg::ALU_PASS_B;
        use_imm_o   = 1'b1;
        reg_write_o = 1'b1;
      end
      rv_pkg::OPC_LOAD: begin
        // Word loads only, address is rs1 + imm
        use_imm_o   = (funct3 == 3'b010);
        reg_write_o = (funct3 == 3'b010);
        mem_read_o  = (funct3 == 3'b010);
      end
      rv_pkg::OPC_STORE: begin
        imm_o       = imm_s_type;
        use_imm_o   = 1'b1;
        mem_write_o = (funct3 == 3'b010);
      end
      rv_pkg::OPC_BRANCH: begin
        // BEQ and BNE share the equality compare
        imm_o       = imm_b_type;
        alu_op_o    = rv_pkg::ALU_EQ;
        branch_o    = (funct3 == 3'b000) || (funct3 == 3'b001);
        branch_ne_o = (funct3 == 3'b001);
      end
      default: begin
      end
    endcase
  end

endmodule

//--- source/fetch_unit.sv
`timescale 1ns/1ps
module fetch_unit #(
  parameter rv_pkg::word_t RESET_PC = 32'h0000_0000
) (
  input  logic          clk_i,
  input  logic          rst_ni,
  input  logic          stall_i,
  input  logic          redirect_i,
  input  rv_pkg::word_t target_i,
  output rv_pkg::word_t pc_o
);

  rv_pkg::word_t pc_q;

  // Redirect from execute wins over a load-use stall
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pc_q <= RESET_PC;
    end else if (redirect_i) begin
      pc_q <= target_i;
    end else if (!stall_i) begin
      // Sequential fetch, one word per cycle
      pc_q <= pc_q + 32'd4;
    end
  end

  assign pc_o = pc_q;

endmodule

//--- source/hazard_unit.sv
`timescale 1ns/1ps
module hazard_unit (
  input  rv_pkg::reg_addr_t rs1_d_i,
  input  rv_pkg::reg_addr_t rs2_d_i,
  input  rv_pkg::reg_addr_t rs1_e_i,
  input  rv_pkg::reg_addr_t rs2_e_i,
  input  rv_pkg::reg_addr_t rd_e_i,
  input  rv_pkg::reg_addr_t rd_m_i,
  input  rv_pkg::reg_addr_t rd_w_i,
  input  logic              mem_read_e_i,
  input  logic              reg_write_m_i,
  input  logic              reg_write_w_i,
  input  logic              redirect_i,
  output logic              stall_o,
  output logic              flush_o,
  output rv_pkg::fwd_sel_e  fwd_a_o,
  output rv_pkg::fwd_sel_e  fwd_b_o
);

  logic load_use;

  // Youngest producer wins, x0 is never forwarded
  function automatic rv_pkg::fwd_sel_e pick_source(input rv_pkg::reg_addr_t rs);
    if (reg_write_m_i && (rd_m_i != '0) && (rd_m_i == rs)) begin
      return rv_pkg::FWD_MEM;
    end else if (reg_write_w_i && (rd_w_i != '0) && (rd_w_i == rs)) begin
      return rv_pkg::FWD_WB;
    end
    return rv_pkg::FWD_RF;
  endfunction

  assign fwd_a_o = pick_source(rs1_e_i);
  assign fwd_b_o = pick_source(rs2_e_i);

  // ========================================
  // Load-use stall and branch flush
  // ========================================
  // Load in execute whose result decode needs next cycle
  assign load_use = mem_read_e_i && (rd_e_i != '0) &&
                    ((rd_e_i == rs1_d_i) || (rd_e_i == rs2_d_i));

  // Taken branch squashes the two younger slots
  assign flush_o = redirect_i;
  // Flush overrides stall
  assign stall_o = load_use && !redirect_i;

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps
module reg_file (
  input  logic              clk_i,
  input  logic              rst_ni,
  input  rv_pkg::reg_addr_t rs1_i,
  input  rv_pkg::reg_addr_t rs2_i,
  input  rv_pkg::reg_addr_t rd_i,
  input  logic              we_i,
  input  rv_pkg::word_t     wdata_i,
  output rv_pkg::word_t     rdata1_o,
  output rv_pkg::word_t     rdata2_o
);

  // x0 has no storage
  rv_pkg::word_t regs [1:31];

  // Read port with bypass of the write landing this cycle
  function automatic rv_pkg::word_t read_port(input rv_pkg::reg_addr_t addr);
    if (addr == '0) begin
      return '0;
    end else if (we_i && (rd_i == addr)) begin
      return wdata_i;
    end
    return regs[addr];
  endfunction

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we_i && (rd_i != '0)) begin
      regs[rd_i] <= wdata_i;
    end
  end

  assign rdata1_o = read_port(rs1_i);
  assign rdata2_o = read_port(rs2_i);

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  // ========================================
  // Widths
  // ========================================
  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  // Data, address and instruction word
  typedef logic [XLEN-1:0] word_t;
  // Register index
  typedef logic [REG_AW-1:0] reg_addr_t;

  // ========================================
  // Execute stage encodings
  // ========================================
  // ALU operations, PASS_B serves LUI and EQ serves branches
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_PASS_B = 3'd6,
    ALU_EQ     = 3'd7
  } alu_op_e;

  // Source of an execute operand
  typedef enum logic [1:0] {
    FWD_RF  = 2'd0,
    FWD_MEM = 2'd1,
    FWD_WB  = 2'd2
  } fwd_sel_e;

  // ========================================
  // Opcodes
  // ========================================
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_LUI    = 7'b0110111;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;

  // ADDI x0,x0,0 fills empty pipeline slots
  localparam word_t NOP_INSTR = 32'h0000_0013;

endpackage

//--- tests/cpu_sva.sv
`timescale 1ns/1ps
module cpu_sva (
  input logic          clk_i,
  input logic          rst_ni,
  input rv_pkg::word_t imem_addr_o,
  input logic          dmem_we_o,
  input logic          dmem_re_o
);

  // Failed assertion count
  int fail_cnt = 0;

  // A single memory stage holds either a load or a store
  we_re_exclusive: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(dmem_we_o && dmem_re_o)
  ) else begin
    $error("dmem_we_o and dmem_re_o high in the same cycle");
    fail_cnt++;
  end

  // Fetch only from word addresses
  fetch_aligned: assert property (
    @(posedge clk_i) disable iff (!rst_ni) (imem_addr_o[1:0] == 2'b00)
  ) else begin
    $error("imem_addr_o not word aligned: %h", imem_addr_o);
    fail_cnt++;
  end

  // Pipeline is empty when reset lets go
  no_store_at_release: assert property (
    @(posedge clk_i) $rose(rst_ni) |-> !dmem_we_o
  ) else begin
    $error("dmem_we_o high in the first cycle after reset");
    fail_cnt++;
  end

endmodule

bind cpu_core cpu_sva u_sva (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .imem_addr_o(imem_addr_o),
  .dmem_we_o  (dmem_we_o),
  .dmem_re_o  (dmem_re_o)
);

//--- tests/tb_clock.sv
`timescale 1ns/1ps
module tb_clock #(
  parameter int RESET_CYCLES = 8
) (
  input  logic reset_req_i,
  output logic clk_o,
  output logic rst_no
);

  int   low_left;
  logic req;

  // 40 ns period
  initial begin
    clk_o = 1'b0;
    forever #20 clk_o = ~clk_o;
  end

  // Reset low for RESET_CYCLES edges at start and after each request
  initial begin
    rst_no   = 1'b0;
    low_left = RESET_CYCLES;
    forever begin
      @(posedge clk_o);
      req = reset_req_i;
      // Change reset just after the edge
      #1;
      if (req) begin
        rst_no   = 1'b0;
        low_left = RESET_CYCLES;
      end else if (low_left > 1) begin
        low_left--;
      end else begin
        low_left = 0;
        rst_no   = 1'b1;
      end
    end
  end

endmodule

//--- tests/tb_cpu.sv
`timescale 1ns/1ps
module tb_cpu;

  localparam rv_pkg::word_t RESET_PC  = 32'h0000_1000;
  localparam rv_pkg::word_t DMEM_BASE = 32'h0000_0100;
  localparam int ROM_WORDS     = 64;
  localparam int DMEM_WORDS    = 16;
  localparam int RAND_LEN      = 24;
  localparam int NUM_RANDOM    = 20;
  localparam int STORE_TIMEOUT = 200;
  localparam int RESET_TIMEOUT = 20;
  localparam int DRAIN_CYCLES  = 12;
  localparam logic [31:0] LFSR_SEED = 32'hbebf_df53;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

  // Instruction kinds of the generated programs
  typedef enum int {
    K_ADD, K_SUB, K_AND, K_OR, K_XOR, K_SLT,
    K_ADDI, K_LUI, K_LW, K_SW, K_BEQ, K_BNE
  } kind_e;

  logic          clk;
  logic          rst_n;
  logic          reset_req;
  rv_pkg::word_t imem_addr, imem_rdata, dmem_addr, dmem_wdata, dmem_rdata;
  logic          dmem_we, dmem_re;
  rv_pkg::word_t rom_idx;
  rv_pkg::word_t rom [ROM_WORDS];
  rv_pkg::word_t ram [DMEM_WORDS];
  // Program held as fields, encoded into the ROM
  kind_e         kind_a [ROM_WORDS];
  int            rd_a   [ROM_WORDS];
  int            rs1_a  [ROM_WORDS];
  int            rs2_a  [ROM_WORDS];
  rv_pkg::word_t imm_a  [ROM_WORDS];
  int            prog_len;
  logic [31:0]   lfsr;
  rv_pkg::word_t exp_addr_q [$];
  rv_pkg::word_t exp_data_q [$];
  rv_pkg::word_t exp_load_q [$];
  int            load_idx;

  tb_clock u_clock (
    .reset_req_i(reset_req),
    .clk_o      (clk),
    .rst_no     (rst_n)
  );

  cpu_core #(
    .RESET_PC(RESET_PC)
  ) uut (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .imem_addr_o (imem_addr),
    .imem_rdata_i(imem_rdata),
    .dmem_addr_o (dmem_addr),
    .dmem_wdata_o(dmem_wdata),
    .dmem_rdata_i(dmem_rdata),
    .dmem_we_o   (dmem_we),
    .dmem_re_o   (dmem_re)
  );

  // ========================================
  // Memory models
  // ========================================
  // ROM answers in the same cycle, NOP outside the program
  assign rom_idx    = (imem_addr - RESET_PC) >> 2;
  assign imem_rdata = (rom_idx < ROM_WORDS) ? rom[rom_idx[5:0]] : rv_pkg::NOP_INSTR;
  assign dmem_rdata = ram[dmem_addr[5:2]];

  // Initial data depends on the full byte address
  function automatic rv_pkg::word_t fill_word(input int idx);
    rv_pkg::word_t addr;
    addr = DMEM_BASE + 32'(idx * 4);
    return (addr * 32'h9e37_79b1) ^ 32'h5a5a_c3c3;
  endfunction

  // RAM refilled during reset, stores land at the edge
  always @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < DMEM_WORDS; i++) begin
        ram[i] <= fill_word(i);
      end
    end else if (dmem_we) begin
      ram[dmem_addr[5:2]] <= dmem_wdata;
    end
  end

  // ========================================
  // Program generation
  // ========================================
  // Galois LFSR, one step per bit
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] val;
    logic        out_bit;
    val = '0;
    for (int i = 0; i < n; i++) begin
      out_bit = lfsr[0];
      lfsr    = (lfsr >> 1) ^ (out_bit ? LFSR_TAPS : 32'h0);
      val     = {val[30:0], out_bit};
    end
    return val;
  endfunction

  task automatic put_instr(input int idx, input kind_e kind, input int rd, input int rs1,
                           input int rs2, input rv_pkg::word_t imm);
    kind_a[idx] = kind;
    rd_a[idx]   = rd;
    rs1_a[idx]  = rs1;
    rs2_a[idx]  = rs2;
    imm_a[idx]  = imm;
  endtask

  // RV32I encodings
  function automatic rv_pkg::word_t encode_instr(input int idx);
    logic [4:0]    rd;
    logic [4:0]    rs1;
    logic [4:0]    rs2;
    rv_pkg::word_t imm;
    rd  = 5'(rd_a[idx]);
    rs1 = 5'(rs1_a[idx]);
    rs2 = 5'(rs2_a[idx]);
    imm = imm_a[idx];
    case (kind_a[idx])
      K_ADD:  return {7'h00, rs2, rs1, 3'b000, rd, rv_pkg::OPC_OP};
      K_SUB:  return {7'h20, rs2, rs1, 3'b000, rd, rv_pkg::OPC_OP};
      K_AND:  return {7'h00, rs2, rs1, 3'b111, rd, rv_pkg::OPC_OP};
      K_OR:   return {7'h00, rs2, rs1, 3'b110, rd, rv_pkg::OPC_OP};
      K_XOR:  return {7'h00, rs2, rs1, 3'b100, rd, rv_pkg::OPC_OP};
      K_SLT:  return {7'h00, rs2, rs1, 3'b010, rd, rv_pkg::OPC_OP};
      K_ADDI: return {imm[11:0], rs1, 3'b000, rd, rv_pkg::OPC_OP_IMM};
      K_LUI:  return {imm[31:12], rd, rv_pkg::OPC_LUI};
      K_LW:   return {imm[11:0], rs1, 3'b010, rd, rv_pkg::OPC_LOAD};
      K_SW:   return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], rv_pkg::OPC_STORE};
      K_BEQ:  return {imm[12], imm[10:5], rs2, rs1, 3'b000, imm[4:1], imm[11],
                      rv_pkg::OPC_BRANCH};
      K_BNE:  return {imm[12], imm[10:5], rs2, rs1, 3'b001, imm[4:1], imm[11],
                      rv_pkg::OPC_BRANCH};
      default: return rv_pkg::NOP_INSTR;
    endcase
  endfunction

  // Forwarding, load-use, taken and not-taken branches, x0 writes
  task automatic make_directed_program();
    prog_len = 23;
    put_instr(0,  K_ADDI, 1, 1 - 1, 0, 32'd5);
    put_instr(1,  K_ADDI, 2, 1, 0, 32'd7);
    put_instr(2,  K_ADD,  3, 1, 2, 32'd0);
    put_instr(3,  K_SUB,  4, 3, 1, 32'd0);
    put_instr(4,  K_SW,   0, 0, 4, DMEM_BASE);
    put_instr(5,  K_SW,   0, 0, 3, DMEM_BASE + 32'h4);
    put_instr(6,  K_LW,   5, 0, 0, DMEM_BASE);
    put_instr(7,  K_ADD,  6, 5, 5, 32'd0);
    put_instr(8,  K_SW,   0, 0, 6, DMEM_BASE + 32'h8);
    put_instr(9,  K_BEQ,  0, 1, 1, 32'd12);
    put_instr(10, K_SW,   0, 0, 1, DMEM_BASE + 32'hc);
    put_instr(11, K_SW,   0, 0, 2, DMEM_BASE + 32'hc);
    put_instr(12, K_BNE,  0, 0, 1, 32'd8);
    put_instr(13, K_SW,   0, 0, 3, DMEM_BASE + 32'h10);
    put_instr(14, K_BEQ,  0, 0, 1, 32'd8);
    put_instr(15, K_ADDI, 0, 1, 0, 32'd99);
    put_instr(16, K_SW,   0, 0, 0, DMEM_BASE + 32'h10);
    put_instr(17, K_LUI,  7, 0, 0, 32'habcd_e000);
    put_instr(18, K_SLT,  6, 7, 4, 32'd0);
    put_instr(19, K_XOR,  5, 7, 6, 32'd0);
    put_instr(20, K_SW,   0, 0, 5, DMEM_BASE + 32'h14);
    put_instr(21, K_SW,   0, 0, 6, DMEM_BASE + 32'h18);
    // BEQ x0,x0 to itself ends every program
    put_instr(22, K_BEQ,  0, 0, 0, 32'd0);
  endtask

  task automatic make_random_program();
    int            sel;
    int            skip;
    logic [31:0]   bits;
    prog_len = RAND_LEN;
    for (int i = 0; i < RAND_LEN - 1; i++) begin
      sel = int'(take_bits(4));
      put_instr(i, K_ADD, int'(take_bits(3)), int'(take_bits(3)), int'(take_bits(3)), '0);
      case (sel)
        0, 1, 2, 3, 4, 5: kind_a[i] = kind_e'(sel);
        6, 7: begin
          bits     = take_bits(12);
          kind_a[i] = K_ADDI;
          imm_a[i]  = {{20{bits[11]}}, bits[11:0]};
        end
        8: begin
          bits     = take_bits(20);
          kind_a[i] = K_LUI;
          imm_a[i]  = {bits[19:0], 12'h000};
        end
        // Memory accesses use base x0 inside the data window
        9, 10, 11, 12, 13: begin
          kind_a[i] = (sel < 11) ? K_LW : K_SW;
          rs1_a[i]  = 0;
          imm_a[i]  = DMEM_BASE + (take_bits(4) << 2);
        end
        default: begin
          // Forward only, never past the final self-loop
          kind_a[i] = (sel == 14) ? K_BEQ : K_BNE;
          skip      = 1 + int'(take_bits(2));
          if (i + skip + 1 > RAND_LEN - 1) begin
            skip = RAND_LEN - 2 - i;
          end
          imm_a[i] = 32'((skip + 1) * 4);
        end
      endcase
    end
    put_instr(RAND_LEN - 1, K_BEQ, 0, 0, 0, 32'd0);
  endtask

  // ========================================
  // Reference model
  // ========================================
  // Architectural run, fills the expected store and load lists in order
  function automatic void run_reference();
    rv_pkg::word_t regs [8];
    rv_pkg::word_t mem  [DMEM_WORDS];
    rv_pkg::word_t a;
    rv_pkg::word_t b;
    rv_pkg::word_t addr;
    int            pc;
    int            nxt_pc;
    int            steps;
    for (int i = 0; i < 8; i++) begin
      regs[i] = '0;
    end
    for (int i = 0; i < DMEM_WORDS; i++) begin
      mem[i] = fill_word(i);
    end
    exp_addr_q.delete();
    exp_data_q.delete();
    exp_load_q.delete();
    pc    = 0;
    steps = 0;
    while ((pc < prog_len - 1) && (steps < 1000)) begin
      a      = regs[rs1_a[pc]];
      b      = regs[rs2_a[pc]];
      addr   = a + imm_a[pc];
      nxt_pc = pc + 1;
      case (kind_a[pc])
        K_ADD:  regs[rd_a[pc]] = a + b;
        K_SUB:  regs[rd_a[pc]] = a - b;
        K_AND:  regs[rd_a[pc]] = a & b;
        K_OR:   regs[rd_a[pc]] = a | b;
        K_XOR:  regs[rd_a[pc]] = a ^ b;
        K_SLT:  regs[rd_a[pc]] = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        K_ADDI: regs[rd_a[pc]] = addr;
        K_LUI:  regs[rd_a[pc]] = imm_a[pc];
        K_LW: begin
          regs[rd_a[pc]] = mem[int'((addr - DMEM_BASE) >> 2)];
          exp_load_q.push_back(addr);
        end
        K_SW: begin
          mem[int'((addr - DMEM_BASE) >> 2)] = b;
          exp_addr_q.push_back(addr);
          exp_data_q.push_back(b);
        end
        K_BEQ:  if (a == b) nxt_pc = pc + int'(imm_a[pc]) / 4;
        K_BNE:  if (a != b) nxt_pc = pc + int'(imm_a[pc]) / 4;
        default: begin
        end
      endcase
      // x0 stays zero
      regs[0] = '0;
      pc      = nxt_pc;
      steps++;
    end
  endfunction

  // ========================================
  // Checks and run control
  // ========================================
  task automatic abort_run();
    $display("=== FAIL ===");
    $fatal(1, "Simulation stopped at the first error");
  endtask

  task automatic report_failure(input string msg);
    $display("%s", msg);
    abort_run();
  endtask

  task automatic check_value(input string name, input rv_pkg::word_t got,
                             input rv_pkg::word_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t ns: %s got %h expected %h", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Each load in the memory stage, in program order
  always @(negedge clk) begin
    if ((rst_n === 1'b1) && (dmem_re === 1'b1)) begin
      if (load_idx < exp_load_q.size()) begin
        check_value("dmem_addr_o", dmem_addr, exp_load_q[load_idx]);
      end
      load_idx++;
    end
  end

  task automatic wait_reset_level(input logic level, input string label);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
      if (cycles > RESET_TIMEOUT) begin
        report_failure($sformatf("Reset never reached level %0b for program %s", level, label));
      end
    end while (rst_n !== level);
  endtask

  task automatic run_program(input string label);
    int            cycles;
    int            n_stores;
    int            tail;
    rv_pkg::word_t loop_pc;
    loop_pc = RESET_PC + 32'((prog_len - 1) * 4);
    @(posedge clk);
    #1 reset_req = 1'b1;
    @(posedge clk);
    #1 reset_req = 1'b0;
    // ROM only changes while the core is held in reset
    wait_reset_level(1'b0, label);
    for (int i = 0; i < ROM_WORDS; i++) begin
      rom[i] = (i < prog_len) ? encode_instr(i) : 32'h0;
    end
    run_reference();
    load_idx = 0;
    wait_reset_level(1'b1, label);
    check_value("imem_addr_o", imem_addr, RESET_PC);
    n_stores = exp_addr_q.size();
    for (int s = 0; s < n_stores; s++) begin
      cycles = 0;
      do begin
        @(negedge clk);
        cycles++;
        if (cycles > STORE_TIMEOUT) begin
          report_failure($sformatf("Store %0d of %0d to %h never arrived in program %s",
                                   s + 1, n_stores, exp_addr_q[s], label));
        end
      end while (dmem_we !== 1'b1);
      check_value("dmem_addr_o", dmem_addr, exp_addr_q[s]);
      check_value("dmem_wdata_o", dmem_wdata, exp_data_q[s]);
    end
    // Squashed paths must never write, up to the final loop and past it
    cycles = 0;
    tail   = 0;
    while (tail < DRAIN_CYCLES) begin
      @(negedge clk);
      cycles++;
      if (dmem_we === 1'b1) begin
        report_failure($sformatf("Extra store to %h after the last one in program %s",
                                 dmem_addr, label));
      end
      if (cycles > STORE_TIMEOUT) begin
        report_failure($sformatf("Fetch never reached the final loop in program %s", label));
      end
      if ((tail > 0) || (imem_addr === loop_pc)) begin
        tail++;
      end
    end
    check_value("dmem_re_o strobes", 32'(load_idx), 32'(exp_load_q.size()));
  endtask

  initial begin
    reset_req = 1'b0;
    load_idx  = 0;
    lfsr      = LFSR_SEED;
    make_directed_program();
    run_program("directed");
    for (int p = 0; p < NUM_RANDOM; p++) begin
      make_random_program();
      run_program($sformatf("random %0d", p));
    end
    if (uut.u_sva.fail_cnt == 0) begin
      $display("=== PASS ===");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule
